//--- include/dfp_defs.svh
`ifndef DFP_DEFS_SVH
`define DFP_DEFS_SVH

// ----------------------------------------------------------------------
// operand format
// ----------------------------------------------------------------------

// significand digits, BCD
`define DFP_DIGITS 7
// biased power-of-ten exponent
`define DFP_EXP_W 8
`define DFP_BIAS 127
// infinity and NaN live here
`define DFP_EXP_SPECIAL 8'hFF

// ----------------------------------------------------------------------
// rounding modes
// ----------------------------------------------------------------------

`define RM_EVEN 2'd0
`define RM_ZERO 2'd1
`define RM_HALFUP 2'd2

`endif

//--- hw/dfpPkg.sv
`include "dfp_defs.svh"

package dfpPkg;

	// packed operand: sign, biased exponent, BCD significand
	typedef logic [1+`DFP_EXP_W+4*`DFP_DIGITS-1:0] dfpWord;

	// biased exponent as stored
	typedef logic [`DFP_EXP_W-1:0] dfpExp;

	// exponent sum, two's complement
	// two extra bits give a sign and room above FF
	typedef logic [`DFP_EXP_W+1:0] dfpExpWide;

	// seven BCD digits
	typedef logic [4*`DFP_DIGITS-1:0] bcdSig;

	// full product, fourteen BCD digits
	typedef logic [8*`DFP_DIGITS-1:0] bcdProd;

	// rounding mode code, see RM_* in the defines
	typedef logic [1:0] roundMode;

	// serial multiplier FSM
	typedef enum logic [1:0] {
		mulIdle,
		mulRun,
		mulFinish
	} mulState;

endpackage

//--- hw/dfpUnpack.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module dfpUnpack (
	input dfpPkg::dfpWord w,
	output logic sign,
	output dfpPkg::dfpExp exp,
	output dfpPkg::bcdSig sig,
	output logic isZero,
	output logic isInf,
	output logic isQnan,
	output logic isSnan
);

	localparam int sigW = 4 * `DFP_DIGITS;

	logic special;
	logic sigZero;
	logic topZero;

	// field split: sign on top, then exponent, then digits
	assign sign = w[sigW+`DFP_EXP_W];
	assign exp = w[sigW+`DFP_EXP_W-1:sigW];
	assign sig = w[sigW-1:0];

	// ------------------------------------------------------------------
	// classification
	// ------------------------------------------------------------------

	assign special = (exp == `DFP_EXP_SPECIAL);
	assign sigZero = (sig == '0);
	// leading digit picks quiet or signaling
	assign topZero = (sig[sigW-1:sigW-4] == 4'h0);

	// any exponent below FF with no digits counts as zero
	assign isZero = sigZero && !special;
	assign isInf = special && sigZero;

	// NaN with a nonzero top digit is quiet
	assign isQnan = special && !sigZero && !topZero;
	// top digit zero, payload below it
	assign isSnan = special && !sigZero && topZero;

endmodule

//--- hw/bcdSerialMul.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module bcdSerialMul (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic ld,
	input dfpPkg::bcdSig a,
	input dfpPkg::bcdSig b,
	output dfpPkg::bcdProd p,
	output logic prodValid
);
	import dfpPkg::*;

	localparam int nDig = `DFP_DIGITS;
	localparam int sigW = 4 * nDig;

	mulState state;
	logic [2:0] cnt;
	bcdSig mcand;
	bcdSig mplier;
	bcdProd acc;
	bcdProd accNext;
	// one digit wider than a significand
	logic [sigW+3:0] multiple;
	logic [sigW+3:0] sumHi;

	// ------------------------------------------------------------------
	// multiple = multiplicand * current multiplier digit
	// ------------------------------------------------------------------

	always_comb begin
		logic [sigW+3:0] mcandX;
		logic [3:0] dig;
		logic [6:0] pd;
		logic [3:0] prevHi;
		logic [4:0] s;
		logic cy;
		int i;
		mcandX = {4'h0, mcand};
		dig = mplier[3:0];
		prevHi = 4'h0;
		cy = 1'b0;
		for (i = 0; i <= nDig; i++) begin
			// digit product is at most 81
			pd = 7'(mcandX[4*i +: 4]) * 7'(dig);
			// units of this digit plus tens of the one below
			s = 5'(pd % 7'd10) + 5'(prevHi) + 5'(cy);
			prevHi = 4'(pd / 7'd10);
			// decimal carry correction
			if (s > 5'd9) begin
				multiple[4*i +: 4] = 4'(s - 5'd10);
				cy = 1'b1;
			end else begin
				multiple[4*i +: 4] = s[3:0];
				cy = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// add multiple into upper half, then shift one digit right
	// ------------------------------------------------------------------

	always_comb begin
		logic [sigW+3:0] accHi;
		logic [4:0] s;
		logic cy;
		int i;
		accHi = {4'h0, acc[2*sigW-1:sigW]};
		cy = 1'b0;
		for (i = 0; i <= nDig; i++) begin
			s = 5'(multiple[4*i +: 4]) + 5'(accHi[4*i +: 4]) + 5'(cy);
			if (s > 5'd9) begin
				sumHi[4*i +: 4] = 4'(s - 5'd10);
				cy = 1'b1;
			end else begin
				sumHi[4*i +: 4] = s[3:0];
				cy = 1'b0;
			end
		end
		// the lowest digit falls out into the finished part
		accNext = {sumHi, acc[sigW-1:4]};
	end

	// control: ld always restarts, even mid-run
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= mulIdle;
			cnt <= '0;
			prodValid <= 1'b0;
		end else if (ce) begin
			prodValid <= 1'b0;
			if (ld) begin
				state <= mulRun;
				cnt <= '0;
			end else begin
				case (state)
					mulRun: begin
						cnt <= cnt + 3'd1;
						// last digit goes in on this edge
						if (cnt == 3'(nDig - 1)) begin
							state <= mulFinish;
							prodValid <= 1'b1;
						end
					end
					mulFinish: state <= mulIdle;
					default: state <= mulIdle;
				endcase
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (ce) begin
			if (ld) begin
				mcand <= a;
				mplier <= b;
				acc <= '0;
			end else if (state == mulRun) begin
				acc <= accNext;
				mplier <= {4'h0, mplier[sigW-1:4]};
			end
		end
	end

	assign p = acc;

endmodule

//--- hw/dfpMulCore.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module dfpMulCore (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic ld,
	input logic sa,
	input logic sb,
	input dfpPkg::dfpExp ea,
	input dfpPkg::dfpExp eb,
	input dfpPkg::bcdSig siga,
	input dfpPkg::bcdSig sigb,
	input logic aZero,
	input logic aInf,
	input logic aQnan,
	input logic aSnan,
	input logic bZero,
	input logic bInf,
	input logic bQnan,
	input logic bSnan,
	input dfpPkg::roundMode rmIn,
	output dfpPkg::bcdProd p,
	output dfpPkg::dfpExpWide expSum,
	output logic sign,
	output dfpPkg::roundMode rm,
	output logic forceNan,
	output logic forceInf,
	output logic forceZero,
	output logic invalid,
	output logic coreValid
);
	import dfpPkg::*;

	bcdProd prod;
	logic prodValid;
	dfpExpWide expNext;
	logic nanIn;
	logic infTimesZero;
	logic nanNext;
	logic invalidNext;
	logic infNext;
	logic zeroNext;

	// significand product, seven cycles after ld
	bcdSerialMul uMul (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.ld(ld),
		.a(siga),
		.b(sigb),
		.p(prod),
		.prodValid(prodValid)
	);

	// ------------------------------------------------------------------
	// exponent and exception decisions, taken at ld
	// ------------------------------------------------------------------

	// unbiased sum rebiased once; may go negative or past FF
	assign expNext = {2'b00, ea} + {2'b00, eb} - 10'(`DFP_BIAS);

	assign nanIn = aQnan || aSnan || bQnan || bSnan;
	assign infTimesZero = (aInf && bZero) || (bInf && aZero);

	assign nanNext = nanIn || infTimesZero;
	// only signaling inputs and inf*0 raise invalid
	assign invalidNext = aSnan || bSnan || infTimesZero;
	assign infNext = (aInf || bInf) && !nanNext;
	assign zeroNext = (aZero || bZero) && !nanNext && !infNext;

	// decisions and handoff strobe
	always_ff @(posedge clk) begin
		if (!rstN) begin
			forceNan <= 1'b0;
			forceInf <= 1'b0;
			forceZero <= 1'b0;
			invalid <= 1'b0;
			coreValid <= 1'b0;
		end else if (ce) begin
			// a fresh ld drops the product still in flight
			coreValid <= prodValid && !ld;
			if (ld) begin
				forceNan <= nanNext;
				forceInf <= infNext;
				forceZero <= zeroNext;
				invalid <= invalidNext;
			end
		end
	end

	// operation fields
	always_ff @(posedge clk) begin
		if (ce) begin
			if (ld) begin
				sign <= sa ^ sb;
				rm <= rmIn;
				expSum <= expNext;
			end
			if (prodValid && !ld) begin
				p <= prod;
			end
		end
	end

endmodule

//--- hw/dfpRound.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module dfpRound (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic coreValid,
	input dfpPkg::bcdProd p,
	input dfpPkg::dfpExpWide expSum,
	input logic sign,
	input dfpPkg::roundMode rm,
	input logic forceNan,
	input logic forceInf,
	input logic forceZero,
	input logic invalid,
	output dfpPkg::dfpWord o,
	output logic inf,
	output logic overflow,
	output logic underflow,
	output logic invalidOut,
	output logic done
);
	import dfpPkg::*;

	localparam int nDig = `DFP_DIGITS;
	localparam int sigW = 4 * nDig;
	// 1000000, also the canonical quiet NaN significand
	localparam bcdSig leadOne = {4'h1, {(sigW-4){1'b0}}};

	logic [3:0] lz;
	logic [3:0] shift;
	bcdProd shifted;
	bcdSig sigKeep;
	logic [3:0] guard;
	logic sticky;
	logic roundUp;
	bcdSig sigInc;
	logic incCarry;
	bcdSig sigRnd;
	dfpExpWide expRnd;
	logic ovf;
	logic unf;
	dfpWord result;
	logic infNext;
	logic ovfNext;
	logic unfNext;

	// ------------------------------------------------------------------
	// normalize: keep the top seven significant digits
	// ------------------------------------------------------------------

	always_comb begin
		logic seen;
		int i;
		lz = '0;
		seen = 1'b0;
		for (i = 2*nDig-1; i >= 0; i--) begin
			if (!seen && p[4*i +: 4] == 4'h0) begin
				lz = lz + 4'd1;
			end else begin
				seen = 1'b1;
			end
		end
		// seven or fewer significant digits, no shift
		shift = (lz < 4'(nDig)) ? 4'(nDig) - lz : 4'd0;
	end

	// guard is the highest dropped digit, sticky the rest
	always_comb begin
		int i;
		shifted = p >> (4 * shift);
		sigKeep = shifted[sigW-1:0];
		guard = 4'h0;
		sticky = 1'b0;
		for (i = 0; i < nDig; i++) begin
			if (i + 1 == shift) begin
				guard = p[4*i +: 4];
			end else if (i + 1 < shift) begin
				sticky = sticky || (p[4*i +: 4] != 4'h0);
			end
		end
	end

	// ------------------------------------------------------------------
	// rounding
	// ------------------------------------------------------------------

	always_comb begin
		case (rm)
			`RM_ZERO: roundUp = 1'b0;
			`RM_HALFUP: roundUp = (guard >= 4'd5);
			// nearest-even; unused code 3 lands here too
			default: roundUp = (guard > 4'd5) || (guard == 4'd5 && (sticky || sigKeep[0]));
		endcase
	end

	// decimal increment, ripple over the digits
	always_comb begin
		logic cy;
		int i;
		cy = roundUp;
		for (i = 0; i < nDig; i++) begin
			if (cy && sigKeep[4*i +: 4] == 4'd9) begin
				sigInc[4*i +: 4] = 4'h0;
			end else begin
				sigInc[4*i +: 4] = sigKeep[4*i +: 4] + 4'(cy);
				cy = 1'b0;
			end
		end
		incCarry = cy;
	end

	// 9999999 rounded up becomes 1000000, one decade higher
	assign sigRnd = incCarry ? leadOne : sigInc;
	assign expRnd = expSum + 10'(shift) + 10'(incCarry);

	// range check on the two's complement exponent
	assign unf = expRnd[`DFP_EXP_W+1];
	assign ovf = !unf && (expRnd >= 10'(`DFP_EXP_SPECIAL));

	// ------------------------------------------------------------------
	// exceptions and packing
	// ------------------------------------------------------------------

	always_comb begin
		infNext = 1'b0;
		ovfNext = 1'b0;
		unfNext = 1'b0;
		if (forceNan) begin
			// always the positive canonical quiet NaN
			result = {1'b0, `DFP_EXP_SPECIAL, leadOne};
		end else if (forceInf) begin
			result = {sign, `DFP_EXP_SPECIAL, {sigW{1'b0}}};
			infNext = 1'b1;
		end else if (forceZero) begin
			result = {sign, {`DFP_EXP_W{1'b0}}, {sigW{1'b0}}};
		end else if (ovf) begin
			result = {sign, `DFP_EXP_SPECIAL, {sigW{1'b0}}};
			infNext = 1'b1;
			ovfNext = 1'b1;
		end else if (unf) begin
			// no denormals, flush to signed zero
			result = {sign, {`DFP_EXP_W{1'b0}}, {sigW{1'b0}}};
			unfNext = 1'b1;
		end else begin
			result = {sign, expRnd[`DFP_EXP_W-1:0], sigRnd};
		end
	end

	// outputs hold until the next result
	always_ff @(posedge clk) begin
		if (!rstN) begin
			o <= '0;
			inf <= 1'b0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			invalidOut <= 1'b0;
			done <= 1'b0;
		end else if (ce) begin
			done <= coreValid;
			if (coreValid) begin
				o <= result;
				inf <= infNext;
				overflow <= ovfNext;
				underflow <= unfNext;
				invalidOut <= invalid;
			end
		end else begin
			// done stays a single clock even across a stall
			done <= 1'b0;
		end
	end

endmodule

//--- hw/dfpMul.sv
`timescale 1ns/1ps

module dfpMul (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic ld,
	input dfpPkg::dfpWord a,
	input dfpPkg::dfpWord b,
	input dfpPkg::roundMode rm,
	output dfpPkg::dfpWord o,
	output logic inf,
	output logic overflow,
	output logic underflow,
	output logic invalid,
	output logic done
);
	import dfpPkg::*;

	// unpacked operand a
	logic signA, zeroA, infA, qnanA, snanA;
	dfpExp expA;
	bcdSig sigA;
	// unpacked operand b
	logic signB, zeroB, infB, qnanB, snanB;
	dfpExp expB;
	bcdSig sigB;

	// core to rounder
	bcdProd prod;
	dfpExpWide expSum;
	roundMode rmCore;
	logic signCore, forceNan, forceInf, forceZero, invalidCore, coreValid;

	dfpUnpack uUnpackA (
		.w(a), .sign(signA), .exp(expA), .sig(sigA),
		.isZero(zeroA), .isInf(infA), .isQnan(qnanA), .isSnan(snanA)
	);

	dfpUnpack uUnpackB (
		.w(b), .sign(signB), .exp(expB), .sig(sigB),
		.isZero(zeroB), .isInf(infB), .isQnan(qnanB), .isSnan(snanB)
	);

	// exponent, sign, exceptions and the serial significand multiply
	dfpMulCore uCore (
		.clk(clk), .rstN(rstN), .ce(ce), .ld(ld),
		.sa(signA), .sb(signB), .ea(expA), .eb(expB), .siga(sigA), .sigb(sigB),
		.aZero(zeroA), .aInf(infA), .aQnan(qnanA), .aSnan(snanA),
		.bZero(zeroB), .bInf(infB), .bQnan(qnanB), .bSnan(snanB),
		.rmIn(rm), .p(prod), .expSum(expSum), .sign(signCore), .rm(rmCore),
		.forceNan(forceNan), .forceInf(forceInf), .forceZero(forceZero),
		.invalid(invalidCore), .coreValid(coreValid)
	);

	// normalize, round, pack
	dfpRound uRound (
		.clk(clk), .rstN(rstN), .ce(ce), .coreValid(coreValid),
		.p(prod), .expSum(expSum), .sign(signCore), .rm(rmCore),
		.forceNan(forceNan), .forceInf(forceInf), .forceZero(forceZero),
		.invalid(invalidCore), .o(o), .inf(inf), .overflow(overflow),
		.underflow(underflow), .invalidOut(invalid), .done(done)
	);

endmodule

//--- tests/dfpMul_properties.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module dfpMulProperties (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic ld,
	input dfpPkg::dfpWord o,
	input logic inf,
	input logic overflow,
	input logic invalid,
	input logic done
);

	localparam int sigW = 4 * `DFP_DIGITS;

	// enabled cycles since the last accepted ld, parks at F
	logic [3:0] sinceLd;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			sinceLd <= 4'hF;
		end else if (ce && ld) begin
			sinceLd <= '0;
		end else if (ce && sinceLd != 4'hF) begin
			sinceLd <= sinceLd + 4'd1;
		end
	end

	// ------------------------------------------------------------------
	// handshake timing
	// ------------------------------------------------------------------

	donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else $error("done high for two cycles");

	// done only on the ninth enabled edge after ld
	doneLate: assert property (@(posedge clk) disable iff (!rstN) done |-> sinceLd == 4'd9)
		else $error("done not 9 enabled cycles after ld");

	doneDue: assert property (@(posedge clk) disable iff (!rstN)
		(ce && !ld && sinceLd == 4'd8) |=> done)
		else $error("done missing 9 enabled cycles after ld");

	// ------------------------------------------------------------------
	// flag consistency
	// ------------------------------------------------------------------

	ovfInf: assert property (@(posedge clk) disable iff (!rstN) overflow |-> inf)
		else $error("overflow without inf");

	// invalid only ever comes with the canonical NaN
	invNan: assert property (@(posedge clk) disable iff (!rstN)
		invalid |-> (o[sigW +: `DFP_EXP_W] == `DFP_EXP_SPECIAL && o[sigW-1:0] != '0))
		else $error("invalid without a NaN result");

endmodule

bind dfpMul dfpMulProperties props (
	.clk(clk), .rstN(rstN), .ce(ce), .ld(ld), .o(o),
	.inf(inf), .overflow(overflow), .invalid(invalid), .done(done)
);

//--- tests/dfpMulTb.sv
`timescale 1ns/1ps
`include "dfp_defs.svh"

module dfpMulTb;
	import dfpPkg::*;

	localparam int sigW = 4 * `DFP_DIGITS;
	localparam int nRandom = 400;
	localparam int nDirected = 13;
	// 20 cycles per operation covers stalls and restarts
	localparam longint watchdogNs = longint'((nRandom + nDirected) * 20 + 100) * 10;
	localparam longint sigLimit = 64'd10 ** `DFP_DIGITS;
	// operand classes for the model
	localparam int clsFinite = 0;
	localparam int clsZero = 1;
	localparam int clsInf = 2;
	localparam int clsQnan = 3;
	localparam int clsSnan = 4;

	logic clk;
	logic rstN;
	logic ce;
	logic ld;
	dfpWord a;
	dfpWord b;
	roundMode rm;
	dfpWord o;
	logic inf;
	logic overflow;
	logic underflow;
	logic invalid;
	logic done;

	int errCount;
	int opCount;
	bit [31:0] rngState;

	dfpMul dut (
		.clk(clk), .rstN(rstN), .ce(ce), .ld(ld), .a(a), .b(b), .rm(rm),
		.o(o), .inf(inf), .overflow(overflow), .underflow(underflow),
		.invalid(invalid), .done(done)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// watchdog
	initial begin
		#(watchdogNs);
		$display("timeout: run still going after %0d ns", watchdogNs);
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// random numbers and operands
	// ------------------------------------------------------------------

	function automatic bit [31:0] xorshift(input bit [31:0] x);
		bit [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int unsigned nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// 1 to 7 random low digits, so products vary in length
	function automatic bcdSig randSig();
		bcdSig s;
		int nd;
		int i;
		s = '0;
		nd = 1 + int'(nextRand() % 7);
		for (i = 0; i < nd; i++) begin
			s[4*i +: 4] = 4'(nextRand() % 10);
		end
		return s;
	endfunction

	function automatic dfpWord randOperand();
		int unsigned kind;
		dfpExp e;
		bcdSig s;
		kind = nextRand() % 16;
		// near the bias by default
		e = dfpExp'(`DFP_BIAS - 20 + int'(nextRand() % 40));
		s = randSig();
		case (kind)
			0: s = '0;
			1: begin
				e = `DFP_EXP_SPECIAL;
				s = '0;
			end
			2: begin
				e = `DFP_EXP_SPECIAL;
				s[sigW-1 -: 4] = 4'(1 + nextRand() % 9);
			end
			3: begin
				e = `DFP_EXP_SPECIAL;
				s[sigW-1 -: 4] = 4'h0;
				s[3:0] = 4'(1 + nextRand() % 9);
			end
			// exponents near both ends of the range
			4, 5: e = dfpExp'(240 + int'(nextRand() % 15));
			6, 7: e = dfpExp'(nextRand() % 16);
			default: ;
		endcase
		return {1'(nextRand() % 2), e, s};
	endfunction

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	function automatic longint bcdToInt(input bcdSig s);
		longint v;
		int i;
		v = 0;
		for (i = `DFP_DIGITS - 1; i >= 0; i--) begin
			v = v * 10 + longint'(s[4*i +: 4]);
		end
		return v;
	endfunction

	function automatic bcdSig intToBcd(input longint v);
		bcdSig s;
		longint t;
		int i;
		t = v;
		for (i = 0; i < `DFP_DIGITS; i++) begin
			s[4*i +: 4] = 4'(t % 10);
			t = t / 10;
		end
		return s;
	endfunction

	function automatic dfpWord packWord(input bit s, input int e, input longint v);
		return {s, dfpExp'(e), intToBcd(v)};
	endfunction

	function automatic int classOf(input dfpWord w);
		dfpExp e;
		bcdSig s;
		e = w[sigW +: `DFP_EXP_W];
		s = w[sigW-1:0];
		if (e != `DFP_EXP_SPECIAL) begin
			return (s == '0) ? clsZero : clsFinite;
		end
		if (s == '0) begin
			return clsInf;
		end
		// top digit zero marks a signaling NaN
		return (s[sigW-1 -: 4] == 4'h0) ? clsSnan : clsQnan;
	endfunction

	task automatic modelMul(input dfpWord x, input dfpWord y, input roundMode mode,
			output dfpWord r, output bit fInf, output bit fOvf, output bit fUnf,
			output bit fInv);
		int cx;
		int cy;
		bit sgn;
		bit infZero;
		bit up;
		longint prod;
		longint t;
		longint scale;
		longint keep;
		longint rem;
		int nd;
		int drop;
		int e;
		cx = classOf(x);
		cy = classOf(y);
		sgn = x[sigW+`DFP_EXP_W] ^ y[sigW+`DFP_EXP_W];
		infZero = (cx == clsInf && cy == clsZero) || (cx == clsZero && cy == clsInf);
		fInv = (cx == clsSnan) || (cy == clsSnan) || infZero;
		fInf = 1'b0;
		fOvf = 1'b0;
		fUnf = 1'b0;
		if (cx >= clsQnan || cy >= clsQnan || infZero) begin
			r = packWord(1'b0, 255, sigLimit / 10);
		end else if (cx == clsInf || cy == clsInf) begin
			r = packWord(sgn, 255, 0);
			fInf = 1'b1;
		end else if (cx == clsZero || cy == clsZero) begin
			r = packWord(sgn, 0, 0);
		end else begin
			// exact product, then keep the top seven digits
			prod = bcdToInt(x[sigW-1:0]) * bcdToInt(y[sigW-1:0]);
			nd = 0;
			t = prod;
			while (t > 0) begin
				nd++;
				t = t / 10;
			end
			drop = (nd > `DFP_DIGITS) ? nd - `DFP_DIGITS : 0;
			scale = 1;
			repeat (drop) scale = scale * 10;
			keep = prod / scale;
			rem = prod % scale;
			if (drop == 0 || mode == `RM_ZERO) begin
				up = 1'b0;
			end else if (mode == `RM_HALFUP) begin
				up = (rem >= scale / 2);
			end else begin
				up = (rem > scale / 2) || (rem == scale / 2 && keep % 2 == 1);
			end
			keep = keep + longint'(up);
			// carry into an eighth digit
			if (keep == sigLimit) begin
				keep = sigLimit / 10;
				drop++;
			end
			e = int'(x[sigW +: `DFP_EXP_W]) + int'(y[sigW +: `DFP_EXP_W]) - `DFP_BIAS + drop;
			if (e >= 255) begin
				r = packWord(sgn, 255, 0);
				fInf = 1'b1;
				fOvf = 1'b1;
			end else if (e < 0) begin
				r = packWord(sgn, 0, 0);
				fUnf = 1'b1;
			end else begin
				r = packWord(sgn, e, keep);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------

	task automatic checkWord(input string name, input dfpWord got, input dfpWord want);
		if (got !== want) begin
			errCount++;
			$display("ERR %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic checkFlag(input string name, input bit got, input bit want);
		if (got !== want) begin
			errCount++;
			$display("ERR %s got %h expected %h", name, got, want);
		end
	endtask

	// one operation; restart first launches a decoy that gets cut off
	task automatic runOp(input dfpWord opA, input dfpWord opB, input roundMode mode,
			input bit restart);
		dfpWord wantO;
		bit wantInf;
		bit wantOvf;
		bit wantUnf;
		bit wantInv;
		int enCycles;
		int waited;
		if (restart) begin
			@(negedge clk);
			a = randOperand();
			b = randOperand();
			ld = 1'b1;
			ce = 1'b1;
			repeat (4) begin
				@(negedge clk);
				ld = 1'b0;
				if (done) begin
					errCount++;
					$display("done seen while the restarted operation was busy");
				end
			end
		end
		modelMul(opA, opB, mode, wantO, wantInf, wantOvf, wantUnf, wantInv);
		@(negedge clk);
		a = opA;
		b = opB;
		rm = mode;
		ld = 1'b1;
		ce = 1'b1;
		// ld taken on the rising edge in between
		@(negedge clk);
		ld = 1'b0;
		enCycles = 0;
		waited = 0;
		while (!done && waited < 60) begin
			// roughly one stall in eight
			ce = (nextRand() % 8) != 0;
			@(negedge clk);
			if (ce) begin
				enCycles++;
			end
			waited++;
		end
		opCount++;
		if (!done) begin
			errCount++;
			$display("no done within %0d cycles of ld", waited);
		end else begin
			if (enCycles != 9) begin
				errCount++;
				$display("done after %0d enabled cycles instead of 9", enCycles);
			end
			checkWord("o", o, wantO);
			checkFlag("inf", inf, wantInf);
			checkFlag("overflow", overflow, wantOvf);
			checkFlag("underflow", underflow, wantUnf);
			checkFlag("invalid", invalid, wantInv);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial begin
		int i;
		rngState = 32'd40;
		errCount = 0;
		opCount = 0;
		rstN = 1'b0;
		ce = 1'b1;
		ld = 1'b0;
		a = '0;
		b = '0;
		rm = `RM_EVEN;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		checkWord("o", o, '0);
		checkFlag("done", done, 1'b0);

		// 99999996 rounds into a new digit, except toward zero
		runOp(packWord(0, 127, 8333333), packWord(0, 127, 12), `RM_EVEN, 1'b0);
		runOp(packWord(0, 127, 8333333), packWord(0, 127, 12), `RM_ZERO, 1'b0);
		runOp(packWord(1, 127, 8333333), packWord(0, 127, 12), `RM_HALFUP, 1'b0);
		// exact tie on an even digit
		runOp(packWord(0, 127, 4000001), packWord(0, 127, 5), `RM_EVEN, 1'b0);
		runOp(packWord(0, 127, 4000001), packWord(0, 127, 5), `RM_HALFUP, 1'b0);
		// special operands
		runOp(packWord(0, 255, 0), packWord(1, 100, 0), `RM_EVEN, 1'b0);
		runOp(packWord(0, 255, 123456), packWord(0, 127, 42), `RM_EVEN, 1'b0);
		runOp(packWord(1, 255, 5000000), packWord(0, 255, 0), `RM_EVEN, 1'b0);
		runOp(packWord(0, 255, 0), packWord(1, 130, 77), `RM_ZERO, 1'b0);
		runOp(packWord(0, 90, 0), packWord(1, 130, 77), `RM_ZERO, 1'b0);
		// range limits
		runOp(packWord(0, 240, 9999999), packWord(1, 250, 1234567), `RM_EVEN, 1'b0);
		runOp(packWord(1, 3, 25), packWord(0, 4, 4), `RM_HALFUP, 1'b0);
		// ld during a busy operation
		runOp(packWord(0, 127, 1234567), packWord(0, 128, 7654321), `RM_EVEN, 1'b1);

		for (i = 0; i < nRandom; i++) begin
			runOp(randOperand(), randOperand(), roundMode'(nextRand() % 3),
				(nextRand() % 32) == 0);
		end

		@(negedge clk);
		$display("checked %0d operations, %0d errors", opCount, errCount);
		if (errCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+include
hw/dfpPkg.sv
hw/dfpUnpack.sv
hw/bcdSerialMul.sv
hw/dfpMulCore.sv
hw/dfpRound.sv
hw/dfpMul.sv
tests/dfpMul_properties.sv
tests/dfpMulTb.sv

//--- run.sh
#!/bin/sh
# build the dfpMul testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dfpMulTb \
	-o simDfpMul && ./obj_dir/simDfpMul > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log 2>/dev/null && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
